//--- bpu_cfg_pkg.sv
`default_nettype none

package bpu_cfg_pkg;

    localparam int xlen = 32;               // address and instruction width
    localparam int ghist_w = 16;            // global history length

    // bimodal base table, indexed by pc[9:1]
    localparam int bimodal_entries = 512;
    localparam int bimodal_idx_w = 9;
    localparam int bm_idx_lsb = 1;

    // tagged tables T0 and T1
    localparam int num_tagged = 2;
    localparam int tagged_entries = 256;
    localparam int tagged_idx_w = 8;
    localparam int tag_w = 10;
    localparam int partial_tag_bits = 6;    // upper tag bits compared on lookup
    localparam int tag_pc_lsb = 8;          // tag hashes pc[17:8]

    // btb, index pc[9:2], tag is the top of the pc
    localparam int btb_entries = 256;
    localparam int btb_idx_w = 8;
    localparam int btb_idx_lsb = 2;
    localparam int btb_tag_w = 22;

    localparam int ras_depth = 16;
    localparam int ras_ptr_w = 5;           // one extra bit so a full stack fits

    // 2-bit saturating counter values
    localparam logic [1:0] ctr_strong_nt = 2'b00;
    localparam logic [1:0] ctr_weak_nt = 2'b01;
    localparam logic [1:0] ctr_weak_t = 2'b10;
    localparam logic [1:0] ctr_strong_t = 2'b11;

    // instruction fields
    localparam int opcode_w = 7;
    localparam int reg_w = 5;
    localparam int rd_lsb = 7;
    localparam int rs1_lsb = 15;
    localparam int imm_i_lsb = 20;

    localparam logic [opcode_w-1:0] opc_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] opc_jal = 7'b1101111;
    localparam logic [opcode_w-1:0] opc_jalr = 7'b1100111;

    localparam logic [reg_w-1:0] reg_zero = 5'd0;
    localparam logic [reg_w-1:0] reg_ra = 5'd1;    // x1, link register
    localparam logic [reg_w-1:0] reg_t0 = 5'd5;    // x5, alternate link

endpackage

`default_nettype wire

//--- bpu_types_pkg.sv
`default_nettype none

package bpu_types_pkg;

    typedef enum logic [bpu_cfg_pkg::opcode_w-1:0] {
        op_other = 7'b0000000,
        op_branch = bpu_cfg_pkg::opc_branch,
        op_jal = bpu_cfg_pkg::opc_jal,
        op_jalr = bpu_cfg_pkg::opc_jalr
    } opcode_e;

    // which component produced the direction
    typedef enum logic [1:0] {
        prov_base = 2'd0,
        prov_t0 = 2'd1,
        prov_t1 = 2'd2
    } provider_e;

    typedef struct packed {
        logic [bpu_cfg_pkg::xlen-1:0] pc;
        logic [bpu_cfg_pkg::xlen-1:0] inst;
    } fetch_req_t;

    // feedback from execute
    typedef struct packed {
        logic                            valid;
        logic                            taken;
        logic                            correct;   // prediction matched outcome
        logic [bpu_cfg_pkg::xlen-1:0]    pc;
        logic [bpu_cfg_pkg::xlen-1:0]    target;
        logic [bpu_cfg_pkg::xlen-1:0]    inst;
        logic [bpu_cfg_pkg::ghist_w-1:0] history;   // snapshot taken at predict time
        provider_e                       provider;
    } resolve_t;

    typedef struct packed {
        logic      taken;
        provider_e provider;
    } dir_pred_t;

    typedef struct packed {
        logic                         btb_hit;
        logic [bpu_cfg_pkg::xlen-1:0] btb_target;
        logic                         ras_valid;
        logic [bpu_cfg_pkg::xlen-1:0] ras_target;
    } tgt_pred_t;

    typedef struct packed {
        logic                            is_cf;     // control flow instruction
        logic                            taken;
        logic [bpu_cfg_pkg::xlen-1:0]    next_pc;
        provider_e                       provider;
        logic [bpu_cfg_pkg::ghist_w-1:0] history;
    } pred_t;

endpackage

`default_nettype wire

//--- tage_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module tage_predictor (
    input  wire                                clk,
    input  wire                                rst,
    input  wire bpu_types_pkg::fetch_req_t     fetch_i,
    input  wire bpu_types_pkg::resolve_t       resolve_i,
    output bpu_types_pkg::dir_pred_t           dir_o,
    output logic [bpu_cfg_pkg::ghist_w-1:0]    history_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic [ghist_w-1:0] ghist;

    logic [1:0] bm_ctr [bimodal_entries];

    // tagged tables, entry 0 is T0 (short history), entry 1 is T1 (long)
    logic             tg_valid [num_tagged][tagged_entries];
    logic [tag_w-1:0] tg_tag   [num_tagged][tagged_entries];
    logic [1:0]       tg_ctr   [num_tagged][tagged_entries];

    logic [tagged_idx_w-1:0]  f_idx [num_tagged];
    logic [tag_w-1:0]         f_tag [num_tagged];
    logic [num_tagged-1:0]    f_hit;
    logic [bimodal_idx_w-1:0] f_bm_idx;

    logic [tagged_idx_w-1:0]  u_idx [num_tagged];
    logic [tag_w-1:0]         u_tag [num_tagged];
    logic [bimodal_idx_w-1:0] u_bm_idx;
    logic                     u_tbl;      // tagged provider being updated
    logic                     alloc_tbl;
    logic                     t1_same;    // T1 already holds this branch

    function automatic logic [tagged_idx_w-1:0] tg_index(
        input logic [xlen-1:0]    pc,
        input logic [ghist_w-1:0] h,
        input int                 tbl
    );
        if (tbl == 0) begin
            return pc[tagged_idx_w-1:0] ^ h[tagged_idx_w-1:0];
        end
        return pc[tagged_idx_w-1:0] ^ h[ghist_w-1 -: tagged_idx_w];
    endfunction

    function automatic logic [tag_w-1:0] tg_hash(
        input logic [xlen-1:0]    pc,
        input logic [ghist_w-1:0] h,
        input int                 tbl
    );
        if (tbl == 0) begin
            return pc[tag_pc_lsb +: tag_w] ^ h[ghist_w-1 -: tag_w];
        end
        return pc[tag_pc_lsb +: tag_w] ^ tag_w'(h[tagged_idx_w-1:0]);
    endfunction

    function automatic logic [1:0] sat_ctr(input logic [1:0] ctr, input logic up);
        if (up && ctr != ctr_strong_t) begin
            return ctr + 2'd1;
        end
        if (!up && ctr != ctr_strong_nt) begin
            return ctr - 2'd1;
        end
        return ctr;
    endfunction

    // lookup side
    always_comb begin
        for (int t = 0; t < num_tagged; t++) begin
            f_idx[t] = tg_index(fetch_i.pc, ghist, t);
            f_tag[t] = tg_hash(fetch_i.pc, ghist, t);
            u_idx[t] = tg_index(resolve_i.pc, resolve_i.history, t);
            u_tag[t] = tg_hash(resolve_i.pc, resolve_i.history, t);
            f_hit[t] = tg_valid[t][f_idx[t]] &&
                       (tg_tag[t][f_idx[t]][tag_w-1 -: partial_tag_bits] ==
                        f_tag[t][tag_w-1 -: partial_tag_bits]);
        end
    end

    assign f_bm_idx = fetch_i.pc[bm_idx_lsb +: bimodal_idx_w];
    assign u_bm_idx = resolve_i.pc[bm_idx_lsb +: bimodal_idx_w];

    // longest history wins
    always_comb begin
        if (f_hit[1]) begin
            dir_o.taken = tg_ctr[1][f_idx[1]][1];
            dir_o.provider = prov_t1;
        end else if (f_hit[0]) begin
            dir_o.taken = tg_ctr[0][f_idx[0]][1];
            dir_o.provider = prov_t0;
        end else begin
            dir_o.taken = bm_ctr[f_bm_idx][1];
            dir_o.provider = prov_base;
        end
    end

    assign history_o = ghist;

    assign u_tbl = (resolve_i.provider == prov_t1);
    assign t1_same = tg_valid[1][u_idx[1]] && (tg_tag[1][u_idx[1]] == u_tag[1]);
    assign alloc_tbl = !t1_same;    // fall back to T0 when T1 already matches

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < bimodal_entries; i++) begin
                bm_ctr[i] <= ctr_weak_nt;
            end
            for (int t = 0; t < num_tagged; t++) begin
                for (int i = 0; i < tagged_entries; i++) begin
                    tg_valid[t][i] <= 1'b0;
                    tg_tag[t][i] <= '0;
                    tg_ctr[t][i] <= ctr_weak_nt;
                end
            end
        end else if (resolve_i.valid) begin
            ghist <= {ghist[ghist_w-2:0], resolve_i.taken};
            bm_ctr[u_bm_idx] <= sat_ctr(bm_ctr[u_bm_idx], resolve_i.taken);

            if (resolve_i.provider != prov_base) begin
                if (resolve_i.correct) begin
                    tg_ctr[u_tbl][u_idx[u_tbl]] <=
                        sat_ctr(tg_ctr[u_tbl][u_idx[u_tbl]], resolve_i.taken);
                end else begin
                    tg_ctr[u_tbl][u_idx[u_tbl]] <=
                        resolve_i.taken ? ctr_strong_t : ctr_strong_nt;
                end
            end else if (!resolve_i.correct) begin
                tg_valid[alloc_tbl][u_idx[alloc_tbl]] <= 1'b1;
                tg_tag[alloc_tbl][u_idx[alloc_tbl]] <= u_tag[alloc_tbl];
                tg_ctr[alloc_tbl][u_idx[alloc_tbl]] <=
                    resolve_i.taken ? ctr_weak_t : ctr_weak_nt;
            end
        end
    end

endmodule

`default_nettype wire

//--- target_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module target_predictor (
    input  wire                             clk,
    input  wire                             rst,
    input  wire bpu_types_pkg::fetch_req_t  fetch_i,
    input  wire bpu_types_pkg::resolve_t    resolve_i,
    input  wire                             push_valid_i,   // call decoded
    input  wire [bpu_cfg_pkg::xlen-1:0]     push_addr_i,
    input  wire                             stall_i,
    output bpu_types_pkg::tgt_pred_t        tgt_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic                 btb_valid  [btb_entries];
    logic [btb_tag_w-1:0] btb_tag    [btb_entries];
    logic [xlen-1:0]      btb_target [btb_entries];

    logic [xlen-1:0]      ras_mem [ras_depth];
    logic [ras_ptr_w-1:0] ras_sp;       // next free slot
    logic [ras_ptr_w-1:0] top_ptr;
    logic [ras_ptr_w-1:0] sp_popped;

    logic [btb_idx_w-1:0] f_idx;
    logic [btb_idx_w-1:0] u_idx;
    logic [reg_w-1:0]     res_rs1;
    logic                 res_is_ret;
    logic                 do_pop;
    logic                 do_push;

    // btb lookup
    assign f_idx = fetch_i.pc[btb_idx_lsb +: btb_idx_w];
    assign u_idx = resolve_i.pc[btb_idx_lsb +: btb_idx_w];

    assign tgt_o.btb_hit = btb_valid[f_idx] &&
                           (btb_tag[f_idx] == fetch_i.pc[xlen-1 -: btb_tag_w]);
    assign tgt_o.btb_target = btb_target[f_idx];

    // resolved jalr through a link register pops
    assign res_rs1 = resolve_i.inst[rs1_lsb +: reg_w];
    assign res_is_ret = (resolve_i.inst[opcode_w-1:0] == op_jalr) &&
                        (res_rs1 == reg_ra || res_rs1 == reg_t0);

    assign do_pop = resolve_i.valid && resolve_i.taken && res_is_ret && !stall_i &&
                    (ras_sp != '0);
    assign sp_popped = do_pop ? ras_sp - 1'b1 : ras_sp;
    assign do_push = push_valid_i && !stall_i && (sp_popped < ras_ptr_w'(ras_depth));

    assign top_ptr = ras_sp - 1'b1;

    // same-cycle push is forwarded ahead of the stack top
    assign tgt_o.ras_valid = push_valid_i || (ras_sp != '0);
    assign tgt_o.ras_target = push_valid_i ? push_addr_i : ras_mem[top_ptr[ras_ptr_w-2:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < btb_entries; i++) begin
                btb_valid[i] <= 1'b0;
                btb_tag[i] <= '0;
                btb_target[i] <= '0;
            end
        end else if (resolve_i.valid && resolve_i.taken) begin
            btb_valid[u_idx] <= 1'b1;
            btb_tag[u_idx] <= resolve_i.pc[xlen-1 -: btb_tag_w];
            btb_target[u_idx] <= resolve_i.target;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ras_sp <= '0;
            for (int i = 0; i < ras_depth; i++) begin
                ras_mem[i] <= '0;
            end
        end else begin
            if (do_push) begin
                ras_mem[sp_popped[ras_ptr_w-2:0]] <= push_addr_i;   // lands after the pop
                ras_sp <= sp_popped + 1'b1;
            end else begin
                ras_sp <= sp_popped;
            end
        end
    end

endmodule

`default_nettype wire

//--- pred_select.sv
`timescale 1ns/1ps
`default_nettype none

module pred_select (
    input  wire bpu_types_pkg::fetch_req_t          fetch_i,
    input  wire bpu_types_pkg::dir_pred_t           dir_i,
    input  wire bpu_types_pkg::tgt_pred_t           tgt_i,
    input  wire [bpu_cfg_pkg::ghist_w-1:0]          history_i,
    output bpu_types_pkg::pred_t                    pred_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    opcode_e          opc;
    logic [reg_w-1:0] rd;
    logic [reg_w-1:0] rs1;
    logic             is_ret;
    logic [xlen-1:0]  b_off;
    logic [xlen-1:0]  j_off;
    logic [xlen-1:0]  seq_pc;

    always_comb begin
        case (fetch_i.inst[opcode_w-1:0])
            op_branch: opc = op_branch;
            op_jal:    opc = op_jal;
            op_jalr:   opc = op_jalr;
            default:   opc = op_other;
        endcase
    end

    assign rd = fetch_i.inst[rd_lsb +: reg_w];
    assign rs1 = fetch_i.inst[rs1_lsb +: reg_w];

    // jalr x0, 0(ra) or 0(t0)
    assign is_ret = (opc == op_jalr) && (rd == reg_zero) &&
                    (rs1 == reg_ra || rs1 == reg_t0) &&
                    (fetch_i.inst[xlen-1:imm_i_lsb] == '0);

    // b-type and j-type offsets, sign extended
    assign b_off = {{20{fetch_i.inst[31]}}, fetch_i.inst[7], fetch_i.inst[30:25],
                    fetch_i.inst[11:8], 1'b0};
    assign j_off = {{12{fetch_i.inst[31]}}, fetch_i.inst[19:12], fetch_i.inst[20],
                    fetch_i.inst[30:21], 1'b0};

    assign seq_pc = fetch_i.pc + 32'd4;

    always_comb begin
        pred_o.is_cf = (opc != op_other);
        pred_o.taken = 1'b0;
        pred_o.next_pc = seq_pc;
        pred_o.provider = dir_i.provider;
        pred_o.history = history_i;

        case (opc)
            op_jalr: begin
                if (is_ret) begin
                    pred_o.taken = tgt_i.ras_valid;     // empty stack falls through
                    if (tgt_i.ras_valid) begin
                        pred_o.next_pc = tgt_i.ras_target;
                    end
                end else if (tgt_i.btb_hit) begin
                    pred_o.taken = 1'b1;
                    pred_o.next_pc = tgt_i.btb_target;
                end
            end
            op_jal: begin
                pred_o.taken = 1'b1;
                pred_o.next_pc = tgt_i.btb_hit ? tgt_i.btb_target : fetch_i.pc + j_off;
            end
            op_branch: begin
                pred_o.taken = dir_i.taken;
                if (dir_i.taken) begin
                    pred_o.next_pc = tgt_i.btb_hit ? tgt_i.btb_target : fetch_i.pc + b_off;
                end
            end
            default: begin
                pred_o.taken = 1'b0;    // sequential
            end
        endcase
    end

endmodule

`default_nettype wire

//--- bpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_top (
    input  wire                             clk,
    input  wire                             rst,
    input  wire bpu_types_pkg::fetch_req_t  fetch_i,
    input  wire bpu_types_pkg::resolve_t    resolve_i,
    input  wire                             push_valid_i,
    input  wire [bpu_cfg_pkg::xlen-1:0]     push_addr_i,
    input  wire                             stall_i,
    output bpu_types_pkg::pred_t            pred_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    dir_pred_t          dir;
    tgt_pred_t          tgt;
    logic [ghist_w-1:0] history;    // history the direction was computed with

    tage_predictor tage_predictor_i (
        .clk       (clk),
        .rst       (rst),
        .fetch_i   (fetch_i),
        .resolve_i (resolve_i),
        .dir_o     (dir),
        .history_o (history)
    );

    target_predictor target_predictor_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_i      (fetch_i),
        .resolve_i    (resolve_i),
        .push_valid_i (push_valid_i),
        .push_addr_i  (push_addr_i),
        .stall_i      (stall_i),
        .tgt_o        (tgt)
    );

    pred_select pred_select_i (
        .fetch_i   (fetch_i),
        .dir_i     (dir),
        .tgt_i     (tgt),
        .history_i (history),
        .pred_o    (pred_o)
    );

endmodule

`default_nettype wire

//--- bpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_tb;
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int clk_period = 100;
    localparam int rst_cycles = 8;
    localparam int num_steps = 32;

    localparam logic [xlen-1:0] inst_beq = 32'h00000863;    // beq x0, x0, +16
    localparam logic [xlen-1:0] inst_nop = 32'h00000013;    // addi x0, x0, 0
    localparam logic [xlen-1:0] inst_jal = 32'h100000ef;    // jal ra, +256
    localparam logic [xlen-1:0] inst_ret = 32'h00008067;    // jalr x0, 0(ra)

    localparam logic [xlen-1:0] pc_cold = 32'h00000100;     // tag bits zero like a cleared entry
    localparam logic [xlen-1:0] pc_nop = 32'h00001004;
    localparam logic [xlen-1:0] pc_jal = 32'h00000200;      // btb tag zero like a cleared entry
    localparam logic [xlen-1:0] pc_br = 32'h00004040;       // trained branch
    localparam logic [xlen-1:0] pc_ret = 32'h00005080;
    localparam logic [xlen-1:0] pc_other = 32'h00006000;    // clears the history

    typedef struct packed {
        fetch_req_t      fetch;
        resolve_t        res;
        logic            push_valid;
        logic [xlen-1:0] push_addr;
        logic            stall;
        logic            chk;
        pred_t           want;
    } step_t;

    logic            clk;
    logic            rst;
    fetch_req_t      fetch;
    resolve_t        resolve;
    logic            push_valid;
    logic [xlen-1:0] push_addr;
    logic            stall;
    pred_t           pred;

    step_t steps [num_steps];
    int    n_fill;
    int    errors;
    int    checks;

    bpu_top bpu_top_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_i      (fetch),
        .resolve_i    (resolve),
        .push_valid_i (push_valid),
        .push_addr_i  (push_addr),
        .stall_i      (stall),
        .pred_o       (pred)
    );

    function automatic resolve_t build_resolve(
        input logic               taken,
        input logic               correct,
        input logic [xlen-1:0]    pc,
        input logic [xlen-1:0]    target,
        input logic [xlen-1:0]    inst,
        input logic [ghist_w-1:0] hist
    );
        resolve_t r;
        r.valid = 1'b1;
        r.taken = taken;
        r.correct = correct;
        r.pc = pc;
        r.target = target;
        r.inst = inst;
        r.history = hist;
        r.provider = prov_base;     // every resolve here comes from a base prediction
        return r;
    endfunction

    function automatic pred_t expected_pred(
        input logic               is_cf,
        input logic               taken,
        input logic [xlen-1:0]    next_pc,
        input provider_e          prov,
        input logic [ghist_w-1:0] hist
    );
        pred_t p;
        p.is_cf = is_cf;
        p.taken = taken;
        p.next_pc = next_pc;
        p.provider = prov;
        p.history = hist;
        return p;
    endfunction

    task automatic add_step(
        input logic [xlen-1:0] pc,
        input logic [xlen-1:0] inst,
        input resolve_t        res,
        input logic            push_v,
        input logic [xlen-1:0] push_a,
        input logic            stall_v,
        input logic            chk,
        input pred_t           want
    );
        if (n_fill < num_steps) begin
            steps[n_fill].fetch.pc = pc;
            steps[n_fill].fetch.inst = inst;
            steps[n_fill].res = res;
            steps[n_fill].push_valid = push_v;
            steps[n_fill].push_addr = push_a;
            steps[n_fill].stall = stall_v;
            steps[n_fill].chk = chk;
            steps[n_fill].want = want;
        end
        n_fill++;
    endtask

    // expected values follow the predictor rules and a hand-tracked history
    task automatic fill_table();
        add_step(pc_cold, inst_beq, '0, 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b0, pc_cold + 32'd4, prov_base, 16'h0000));
        add_step(pc_nop, inst_nop, '0, 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b0, 1'b0, pc_nop + 32'd4, prov_base, 16'h0000));

        // jal misses the btb, then hits with a new target
        add_step(pc_jal, inst_jal,
                 build_resolve(1'b1, 1'b1, pc_jal, 32'h00003000, inst_jal, 16'h0000),
                 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, pc_jal + 32'h100, prov_base, 16'h0000));
        add_step(pc_jal, inst_jal, '0, 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, 32'h00003000, prov_base, 16'h0001));

        // bimodal 01 -> 10 -> 11
        add_step(pc_br, inst_beq,
                 build_resolve(1'b1, 1'b1, pc_br, pc_br + 32'd16, inst_beq, 16'h0001),
                 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b0, pc_br + 32'd4, prov_base, 16'h0001));
        add_step(pc_br, inst_beq,
                 build_resolve(1'b1, 1'b1, pc_br, pc_br + 32'd16, inst_beq, 16'h0003),
                 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, pc_br + 32'd16, prov_base, 16'h0003));
        add_step(pc_br, inst_beq, '0, 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, pc_br + 32'd16, prov_base, 16'h0007));

        // return stack starting with the push bypass
        add_step(pc_ret, inst_ret, '0, 1'b1, 32'h0000a000, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, 32'h0000a000, prov_base, 16'h0007));
        add_step(pc_ret, inst_ret, '0, 1'b1, 32'h0000b000, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, 32'h0000b000, prov_base, 16'h0007));
        add_step(pc_ret, inst_ret,
                 build_resolve(1'b1, 1'b1, pc_ret, 32'h0000b000, inst_ret, 16'h0007),
                 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, 32'h0000b000, prov_base, 16'h0007));
        add_step(pc_ret, inst_ret, '0, 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, 32'h0000a000, prov_base, 16'h000f));
        add_step(pc_ret, inst_ret, '0, 1'b1, 32'h0000c000, 1'b1, 1'b0,
                 expected_pred(1'b1, 1'b1, 32'h0000c000, prov_base, 16'h000f));
        add_step(pc_ret, inst_ret,
                 build_resolve(1'b1, 1'b1, pc_ret, 32'h0000a000, inst_ret, 16'h000f),
                 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, 32'h0000a000, prov_base, 16'h000f));
        add_step(pc_ret, inst_ret, '0, 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b0, pc_ret + 32'd4, prov_base, 16'h001f));

        // base mispredict with history 0 allocates in T1
        add_step(pc_br, inst_beq,
                 build_resolve(1'b1, 1'b0, pc_br, pc_br + 32'd16, inst_beq, 16'h0000),
                 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, pc_br + 32'd16, prov_base, 16'h001f));
        for (int k = 0; k < ghist_w; k++) begin
            add_step(pc_nop, inst_nop,
                     build_resolve(1'b0, 1'b1, pc_other, '0, inst_beq, 16'h0000),
                     1'b0, '0, 1'b0, 1'b0, '0);
        end
        add_step(pc_br, inst_beq, '0, 1'b0, '0, 1'b0, 1'b1,
                 expected_pred(1'b1, 1'b1, pc_br + 32'd16, prov_t1, 16'h0000));
    endtask

    task automatic check_field(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("[ERROR] time %0d ns: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic compare_pred(input pred_t want);
        check_field("pred_o.is_cf", 32'(want.is_cf), 32'(pred.is_cf));
        check_field("pred_o.taken", 32'(want.taken), 32'(pred.taken));
        check_field("pred_o.next_pc", want.next_pc, pred.next_pc);
        check_field("pred_o.provider", 32'(want.provider), 32'(pred.provider));
        check_field("pred_o.history", 32'(want.history), 32'(pred.history));
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        fetch = '0;
        resolve = '0;
        push_valid = 1'b0;
        push_addr = '0;
        stall = 1'b0;
        errors = 0;
        checks = 0;
        n_fill = 0;
        fill_table();
        assert (n_fill == num_steps) else begin
            errors++;
            $display("step table has %0d entries but %0d were expected", n_fill, num_steps);
        end

        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < num_steps; i++) begin
            @(posedge clk);
            fetch <= steps[i].fetch;
            resolve <= steps[i].res;
            push_valid <= steps[i].push_valid;
            push_addr <= steps[i].push_addr;
            stall <= steps[i].stall;
            @(negedge clk);     // combinational prediction has settled
            if (steps[i].chk) begin
                compare_pred(steps[i].want);
            end
        end

        @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // reset, every step, and some slack
    initial begin
        #((rst_cycles + num_steps + 10) * clk_period);
        $display("watchdog expired before all steps were applied");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bpu.f
bpu_cfg_pkg.sv
bpu_types_pkg.sv
tage_predictor.sv
target_predictor.sv
pred_select.sv
bpu_top.sv
bpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = bpu_tb
FILELIST  = bpu.f
OBJDIR    = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
